// File: build.f
hw/bundlePkg.sv
hw/bundleSequencer.sv
hw/fetchCounter.sv
hw/bundleMem.sv
hw/syllableDecoder.sv
hw/gprFile.sv
hw/bundleFrontEnd.sv
tb/bundleFrontEnd_sva.sv
tb/bundleFrontEnd_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the bundle front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module bundleFrontEnd_tb -Mdir obj_dir

out=$(./obj_dir/VbundleFrontEnd_tb)
echo "$out"
echo "$out" | grep -qx "Testbench passed"

// File: tb/bundleFrontEnd_tb.sv
// Bundle front end testbench
// Directed tests for reset, unit mapping, type classification, FP load
// detection, register operands and multi-bundle sequencing
`timescale 1ns/1ns

module bundleFrontEnd_tb;

	import bundlePkg::*;

	localparam int DEPTH = 256;

	logic clk;
	logic rst_i;
	logic start;
	logic [7:0] startAddr;
	logic [7:0] numBundles;
	logic imemWe;
	logic [7:0] imemAddr;
	logic [BUNDLE_W-1:0] imemData;
	logic regWe;
	logic [RADDR_W-1:0] regAddr;
	logic [REG_W-1:0] regData;
	logic decValid;
	logic [7:0] decAddr;
	logic [1:0] decSlot;
	unitCode decUnit;
	itype decType;
	logic decFpLoad;
	logic [QP_W-1:0] decQp;
	logic [RADDR_W-1:0] decR1;
	logic [REG_W-1:0] opA;
	logic [REG_W-1:0] opB;
	logic busy;
	logic done;

	logic [31:0] lfsr = 32'hce69c8ff;
	int errorCount = 0;
	int cycle = 0;
	int doneCount = 0;
	logic [BUNDLE_W-1:0] bundleModel [DEPTH];
	logic [REG_W-1:0] regModel [128];
	logic [4:0] tmplList [16] = '{5'h0A, 5'h0B, 5'h0C, 5'h0D, 5'h0E, 5'h0F, 5'h10, 5'h11,
		5'h12, 5'h13, 5'h16, 5'h17, 5'h18, 5'h19, 5'h1C, 5'h1D};

	bundleFrontEnd #(.IMEM_DEPTH(DEPTH)) u_bundleFrontEnd (
		.clk(clk),
		.rst_i(rst_i),
		.start(start),
		.startAddr(startAddr),
		.numBundles(numBundles),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.regWe(regWe),
		.regAddr(regAddr),
		.regData(regData),
		.decValid(decValid),
		.decAddr(decAddr),
		.decSlot(decSlot),
		.decUnit(decUnit),
		.decType(decType),
		.decFpLoad(decFpLoad),
		.decQp(decQp),
		.decR1(decR1),
		.opA(opA),
		.opB(opB),
		.busy(busy),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (done === 1'b1)
			doneCount <= doneCount + 1;
	end

	// ==================================================
	// Random bits and reference model
	// ==================================================
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic getBits(input int n, output logic [127:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			v = {v[126:0], lfsr[0]};
		end
	endtask

	task automatic randomSyllable(output logic [SYL_W-1:0] s);
		logic [127:0] v;
		getBits(SYL_W, v);
		s = v[SYL_W-1:0];
	endtask

	// Templates come in pairs that differ only in the stop bit
	function automatic unitCode expUnit(input logic [4:0] t, input int slot);
		unitCode row [3];
		row = '{UNIT_NONE, UNIT_NONE, UNIT_NONE};
		case (t[4:1])
			4'h5: row = '{UNIT_M, UNIT_M, UNIT_I};
			4'h6: row = '{UNIT_M, UNIT_F, UNIT_I};
			4'h7: row = '{UNIT_M, UNIT_M, UNIT_F};
			4'h8: row = '{UNIT_M, UNIT_I, UNIT_B};
			4'h9: row = '{UNIT_M, UNIT_B, UNIT_B};
			4'hB: row = '{UNIT_B, UNIT_B, UNIT_B};
			4'hC: row = '{UNIT_M, UNIT_M, UNIT_B};
			4'hE: row = '{UNIT_M, UNIT_F, UNIT_B};
			default: row = '{UNIT_NONE, UNIT_NONE, UNIT_NONE};
		endcase
		return row[slot];
	endfunction

	function automatic itype expType(input unitCode u, input logic [3:0] maj);
		itype t;
		t = IT_UNIMP;
		if (u == UNIT_M || u == UNIT_I) begin
			if (maj == 4'h8)
				t = IT_ALU;
			else if (maj == 4'h9)
				t = IT_ADD;
			else if (maj >= 4'hC && maj <= 4'hE)
				t = IT_CMP;
		end
		if (u == UNIT_M) begin
			case (maj)
				4'h0, 4'h1: t = IT_MEMMGNT;
				4'h4: t = IT_INTLDREG;
				4'h5: t = IT_INTLDSTIMM;
				4'h6: t = IT_FPLDSTREG;
				4'h7: t = IT_FPLDSTIMM;
				default: ;
			endcase
		end else if (u == UNIT_I) begin
			case (maj)
				4'h0: t = IT_MISC;
				4'h4: t = IT_DEPOSIT;
				4'h5: t = IT_SHIFT;
				4'h6: t = IT_MOVL;
				4'h7: t = IT_MPY;
				default: ;
			endcase
		end else if (u == UNIT_F) begin
			case (maj)
				4'h0, 4'h1: t = IT_FPMISC;
				4'h4: t = IT_FPCMP;
				4'h5: t = IT_FPCLASS;
				4'h8, 4'h9: t = IT_FPFMA;
				4'hA, 4'hB: t = IT_FPFMS;
				4'hC, 4'hD: t = IT_FPFNMA;
				4'hE: t = IT_SELECT;
				default: ;
			endcase
		end else if (u == UNIT_B) begin
			case (maj)
				4'h0: t = IT_INDBRANCH;
				4'h1: t = IT_INDCALL;
				4'h2: t = IT_NOP;
				4'h4: t = IT_RELBRANCH;
				4'h5: t = IT_RELCALL;
				default: ;
			endcase
		end
		return t;
	endfunction

	function automatic logic expFpLoad(input unitCode u, input logic [SYL_W-1:0] s);
		logic [5:0] x6;
		logic base;
		logic paired;
		logic hit;
		x6 = s[35:30];
		base = (x6 <= 6'h0F) || (x6 == 6'h1B) || (x6 >= 6'h20 && x6 <= 6'h27);
		paired = (x6 >= 6'h01 && x6 <= 6'h0F && x6 != 6'h04 && x6 != 6'h08 && x6 != 6'h0C)
			|| (x6 >= 6'h21 && x6 <= 6'h27 && x6 != 6'h24);
		// Index is {m, x}
		case ({s[36], s[27]})
			2'b00: hit = base;
			2'b01: hit = paired || (x6 >= 6'h1C && x6 <= 6'h1F);
			2'b10: hit = base || (x6 >= 6'h2C && x6 <= 6'h2F);
			default: hit = paired;
		endcase
		return (u == UNIT_M) && (s[40:37] == 4'h6) && hit;
	endfunction

	// ==================================================
	// Drivers and checkers
	// ==================================================
	task automatic reportMismatch(input string name, input logic [79:0] exp,
		input logic [79:0] got);
		errorCount++;
		$display("[ERROR] %0t %s: expected %0h, got %0h", $time, name, exp, got);
	endtask

	task automatic writeBundle(input logic [7:0] a, input logic [BUNDLE_W-1:0] d);
		@(posedge clk);
		#1;
		imemWe = 1'b1;
		imemAddr = a;
		imemData = d;
		@(posedge clk);
		#1;
		imemWe = 1'b0;
		bundleModel[a] = d;
	endtask

	task automatic writeReg(input logic [RADDR_W-1:0] a, input logic [REG_W-1:0] d);
		@(posedge clk);
		#1;
		regWe = 1'b1;
		regAddr = a;
		regData = d;
		@(posedge clk);
		#1;
		regWe = 1'b0;
		regModel[a] = d;
	endtask

	task automatic waitValid(output logic ok);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (decValid !== 1'b1 && n < 40);
		ok = (decValid === 1'b1);
		if (!ok) begin
			errorCount++;
			$display("Timed out at %0t waiting for decValid", $time);
		end
	endtask

	task automatic checkSlot(input logic [7:0] a, input int k, input logic [BUNDLE_W-1:0] bun,
		input logic lastOne);
		logic [SYL_W-1:0] s;
		unitCode eu;
		itype et;
		logic ef;
		s = bun[SYL_W*k +: SYL_W];
		eu = expUnit(bun[127:123], k);
		et = expType(eu, s[40:37]);
		ef = expFpLoad(eu, s);
		if (decAddr !== a)
			reportMismatch("decAddr", 80'(a), 80'(decAddr));
		if (decSlot !== 2'(k))
			reportMismatch("decSlot", 80'(k), 80'(decSlot));
		if (decUnit !== eu)
			reportMismatch("decUnit", 80'(eu), 80'(decUnit));
		if (decType !== et)
			reportMismatch("decType", 80'(et), 80'(decType));
		if (decFpLoad !== ef)
			reportMismatch("decFpLoad", 80'(ef), 80'(decFpLoad));
		if (decQp !== s[5:0])
			reportMismatch("decQp", 80'(s[5:0]), 80'(decQp));
		if (decR1 !== s[12:6])
			reportMismatch("decR1", 80'(s[12:6]), 80'(decR1));
		if (opA !== regModel[s[19:13]])
			reportMismatch("opA", regModel[s[19:13]], opA);
		if (opB !== regModel[s[26:20]])
			reportMismatch("opB", regModel[s[26:20]], opB);
		if (done !== lastOne)
			reportMismatch("done", 80'(lastOne), 80'(done));
		// The run is still busy unless this was its final slot
		if (busy !== !lastOne)
			reportMismatch("busy", 80'(!lastOne), 80'(busy));
	endtask

	// Starts a run and checks every slot, optionally poking start mid-run
	task automatic runBundles(input logic [7:0] addr, input logic [7:0] count,
		input logic pokeStart);
		int b;
		int k;
		int startCycle;
		int doneBefore;
		logic [7:0] a;
		logic ok;
		@(posedge clk);
		#1;
		startAddr = addr;
		numBundles = count;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		startCycle = cycle;
		doneBefore = doneCount;
		for (b = 0; b < int'(count); b++) begin
			a = 8'(int'(addr) + b);
			for (k = 0; k < 3; k++) begin
				waitValid(ok);
				if (!ok)
					return;
				if (cycle - startCycle != 3 + 7 * b + 2 * k)
					reportMismatch("decValid cycle", 80'(3 + 7 * b + 2 * k),
						80'(cycle - startCycle));
				checkSlot(a, k, bundleModel[a], (b == int'(count) - 1) && (k == 2));
				if (pokeStart && b == 0 && k == 0) begin
					start = 1'b1;
					startAddr = addr + 8'd77;
					@(posedge clk);
					#1;
					start = 1'b0;
				end
			end
		end
		repeat (3) @(posedge clk);
		#1;
		if (doneCount - doneBefore != 1)
			reportMismatch("done pulses", 80'd1, 80'(doneCount - doneBefore));
		if (busy !== 1'b0)
			reportMismatch("busy", 80'd0, 80'(busy));
	endtask

	// ==================================================
	// Directed tests
	// ==================================================
	task automatic resetTest();
		repeat (5) begin
			@(posedge clk);
			#1;
			if (busy !== 1'b0 || decValid !== 1'b0 || done !== 1'b0) begin
				errorCount++;
				$display("Outputs not low during reset at %0t", $time);
			end
		end
		rst_i = 1'b0;
		// Start inside warm-up must be dropped
		start = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		start = 1'b0;
		repeat (12) begin
			@(posedge clk);
			#1;
			if (busy !== 1'b0 || decValid !== 1'b0 || done !== 1'b0) begin
				errorCount++;
				$display("Start during warm-up was accepted at %0t", $time);
			end
		end
	endtask

	task automatic loadRegisters();
		int i;
		logic [127:0] v;
		for (i = 0; i < 128; i++) begin
			getBits(REG_W, v);
			writeReg(7'(i), v[REG_W-1:0]);
		end
	endtask

	task automatic unitTest();
		int i;
		int k;
		logic [4:0] t;
		logic [SYL_W-1:0] syl [3];
		for (i = 0; i < 18; i++) begin
			if (i < 16)
				t = tmplList[i];
			else
				t = (i == 16) ? 5'h14 : 5'h00;
			for (k = 0; k < 3; k++)
				randomSyllable(syl[k]);
			writeBundle(8'(i), {t, syl[2], syl[1], syl[0]});
		end
		runBundles(8'd0, 8'd18, 1'b0);
	endtask

	task automatic typeTest();
		int i;
		int k;
		logic [4:0] t;
		logic [SYL_W-1:0] syl [3];
		for (i = 0; i < 17; i++) begin
			t = (i < 16) ? tmplList[i] : 5'h1E;
			for (k = 0; k < 3; k++) begin
				randomSyllable(syl[k]);
				syl[k][40:37] = 4'((3 * i + k) % 16);
			end
			writeBundle(8'(32 + i), {t, syl[2], syl[1], syl[0]});
		end
		runBundles(8'd32, 8'd17, 1'b0);
	endtask

	// Two M slots per bundle sweep all {m, x, x6} codes, slot 2 is F
	task automatic fpLoadTest();
		int j;
		int k;
		logic [7:0] c;
		logic [SYL_W-1:0] syl [3];
		for (j = 0; j < 128; j++) begin
			for (k = 0; k < 2; k++) begin
				c = 8'(2 * j + k);
				randomSyllable(syl[k]);
				syl[k][40:37] = 4'h6;
				syl[k][36] = c[7];
				syl[k][35:30] = c[5:0];
				syl[k][27] = c[6];
			end
			randomSyllable(syl[2]);
			syl[2][40:37] = 4'h6;
			writeBundle(8'(100 + j), {5'h0E, syl[2], syl[1], syl[0]});
		end
		runBundles(8'd100, 8'd128, 1'b0);
	endtask

	task automatic operandTest();
		int i;
		int k;
		logic [127:0] v;
		logic [SYL_W-1:0] syl [3];
		for (i = 0; i < 4; i++) begin
			for (k = 0; k < 3; k++) begin
				randomSyllable(syl[k]);
				getBits(REG_W, v);
				writeReg(syl[k][19:13], v[REG_W-1:0]);
				getBits(REG_W, v);
				writeReg(syl[k][26:20], v[REG_W-1:0]);
			end
			writeBundle(8'(240 + i), {5'h10, syl[2], syl[1], syl[0]});
		end
		runBundles(8'd240, 8'd4, 1'b0);
	endtask

	// Runs across the top of bundle memory
	task automatic sequenceTest();
		int i;
		int k;
		logic [SYL_W-1:0] syl [3];
		for (i = 0; i < 4; i++) begin
			for (k = 0; k < 3; k++)
				randomSyllable(syl[k]);
			writeBundle(8'(254 + i), {tmplList[(5 * i) % 16], syl[2], syl[1], syl[0]});
		end
		runBundles(8'd254, 8'd4, 1'b1);
	endtask

	initial begin
		rst_i = 1'b1;
		start = 1'b0;
		startAddr = 8'd0;
		numBundles = 8'd1;
		imemWe = 1'b0;
		imemAddr = 8'd0;
		imemData = '0;
		regWe = 1'b0;
		regAddr = '0;
		regData = '0;
		resetTest();
		loadRegisters();
		unitTest();
		typeTest();
		fpLoadTest();
		operandTest();
		sequenceTest();
		$display("Errors: %0d", errorCount);
		if (errorCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: tb/bundleFrontEnd_sva.sv
// Bundle front end assertions
// Output timing and reset state, bound into the top level
`timescale 1ns/1ns

module bundleFrontEnd_sva (
	input logic clk,
	input logic rst_i,
	input logic decValid,
	input logic done,
	input logic busy
);

	// Reset clears the pulses and the busy level
	resetLow: assert property (@(posedge clk) rst_i |=> (!decValid && !done && !busy))
		else $error("decValid, done or busy high after a reset cycle");

	// A result leaves while the run is still busy, or together with done
	validInRun: assert property (@(posedge clk) disable iff (rst_i)
		decValid |-> (busy || done))
		else $error("decValid outside a busy run");

	singlePulse: assert property (@(posedge clk) disable iff (rst_i)
		decValid |=> !decValid)
		else $error("decValid high in two consecutive cycles");

endmodule

bind bundleFrontEnd bundleFrontEnd_sva u_bundleFrontEnd_sva (
	.clk(clk),
	.rst_i(rst_i),
	.decValid(decValid),
	.done(done),
	.busy(busy)
);

// File: hw/bundleFrontEnd.sv
// Bundle front end top level
// Fetches bundles, decodes each slot and reads its two source registers
`timescale 1ns/1ns

module bundleFrontEnd #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic clk,
	input  logic rst_i,
	input  logic start,
	input  logic [$clog2(IMEM_DEPTH)-1:0] startAddr,
	input  logic [7:0] numBundles,
	input  logic imemWe,
	input  logic [$clog2(IMEM_DEPTH)-1:0] imemAddr,
	input  logic [bundlePkg::BUNDLE_W-1:0] imemData,
	input  logic regWe,
	input  logic [bundlePkg::RADDR_W-1:0] regAddr,
	input  logic [bundlePkg::REG_W-1:0] regData,
	output logic decValid,
	output logic [$clog2(IMEM_DEPTH)-1:0] decAddr,
	output logic [1:0] decSlot,
	output bundlePkg::unitCode decUnit,
	output bundlePkg::itype decType,
	output logic decFpLoad,
	output logic [bundlePkg::QP_W-1:0] decQp,
	output logic [bundlePkg::RADDR_W-1:0] decR1,
	output logic [bundlePkg::REG_W-1:0] opA,
	output logic [bundlePkg::REG_W-1:0] opB,
	output logic busy,
	output logic done
);

	import bundlePkg::*;

	localparam int AW = $clog2(IMEM_DEPTH);

	logic warmStep;
	logic loadBundle;
	logic selSlot;
	logic rdReg;
	logic nextSlot;
	logic nextBundle;
	logic warmDone;
	logic lastSlot;
	logic lastBundle;
	logic [AW-1:0] bundleAddr;
	logic [1:0] slot;
	logic [BUNDLE_W-1:0] bundle;
	logic [RADDR_W-1:0] r2;
	logic [RADDR_W-1:0] r3;

	bundleSequencer u_bundleSequencer (
		.clk(clk),
		.rst_i(rst_i),
		.start(start),
		.warmDone(warmDone),
		.lastSlot(lastSlot),
		.lastBundle(lastBundle),
		.warmStep(warmStep),
		.loadBundle(loadBundle),
		.selSlot(selSlot),
		.rdReg(rdReg),
		.nextSlot(nextSlot),
		.nextBundle(nextBundle),
		.decValid(decValid),
		.busy(busy),
		.done(done)
	);

	fetchCounter #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetchCounter (
		.clk(clk),
		.rst_i(rst_i),
		.start(start),
		.startAddr(startAddr),
		.numBundles(numBundles),
		.warmStep(warmStep),
		.nextSlot(nextSlot),
		.nextBundle(nextBundle),
		.bundleAddr(bundleAddr),
		.slot(slot),
		.warmDone(warmDone),
		.lastSlot(lastSlot),
		.lastBundle(lastBundle)
	);

	bundleMem #(.IMEM_DEPTH(IMEM_DEPTH)) u_bundleMem (
		.clk(clk),
		.we(imemWe),
		.wrAddr(imemAddr),
		.wrData(imemData),
		.loadBundle(loadBundle),
		.rdAddr(bundleAddr),
		.bundle(bundle)
	);

	// Decoder also carries the bundle address and slot of the latched syllable
	syllableDecoder #(.IMEM_DEPTH(IMEM_DEPTH)) u_syllableDecoder (
		.clk(clk),
		.rst_i(rst_i),
		.bundle(bundle),
		.slot(slot),
		.selSlot(selSlot),
		.addrIn(bundleAddr),
		.unit(decUnit),
		.itype(decType),
		.fpLoad(decFpLoad),
		.qp(decQp),
		.r1(decR1),
		.r2(r2),
		.r3(r3),
		.addrOut(decAddr),
		.slotOut(decSlot)
	);

	gprFile u_gprFile (
		.clk(clk),
		.we(regWe),
		.wa(regAddr),
		.wd(regData),
		.rdReg(rdReg),
		.ra0(r2),
		.ra1(r3),
		.o0(opA),
		.o1(opB)
	);

endmodule

// File: hw/gprFile.sv
// General register file
// 128 entries of 80 bits, one write port and two read ports
// whose addresses are captured on rdReg
`timescale 1ns/1ns

module gprFile (
	input  logic clk,
	input  logic we,
	input  logic [bundlePkg::RADDR_W-1:0] wa,
	input  logic [bundlePkg::REG_W-1:0] wd,
	input  logic rdReg,
	input  logic [bundlePkg::RADDR_W-1:0] ra0,
	input  logic [bundlePkg::RADDR_W-1:0] ra1,
	output logic [bundlePkg::REG_W-1:0] o0,
	output logic [bundlePkg::REG_W-1:0] o1
);

	import bundlePkg::*;

	logic [REG_W-1:0] regs [2**RADDR_W];
	logic [RADDR_W-1:0] ra0Q;
	logic [RADDR_W-1:0] ra1Q;

	always_ff @(posedge clk) begin
		if (we)
			regs[wa] <= wd;
		if (rdReg) begin
			ra0Q <= ra0;
			ra1Q <= ra1;
		end
	end

	// No write bypass, reads see the stored value
	assign o0 = regs[ra0Q];
	assign o1 = regs[ra1Q];

endmodule

// File: hw/syllableDecoder.sv
// Syllable decoder
// Latches the template and one syllable, then finds the target unit,
// the coarse instruction type and whether it is a floating-point load
`timescale 1ns/1ns

module syllableDecoder #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic clk,
	input  logic rst_i,
	input  logic [bundlePkg::BUNDLE_W-1:0] bundle,
	input  logic [1:0] slot,
	input  logic selSlot,
	input  logic [$clog2(IMEM_DEPTH)-1:0] addrIn,
	output bundlePkg::unitCode unit,
	output bundlePkg::itype itype,
	output logic fpLoad,
	output logic [bundlePkg::QP_W-1:0] qp,
	output logic [bundlePkg::RADDR_W-1:0] r1,
	output logic [bundlePkg::RADDR_W-1:0] r2,
	output logic [bundlePkg::RADDR_W-1:0] r3,
	output logic [$clog2(IMEM_DEPTH)-1:0] addrOut,
	output logic [1:0] slotOut
);

	import bundlePkg::*;

	logic [4:0] tmpl;
	logic [SYL_W-1:0] slotBits;
	syllable_u syl;
	unitCode u0;
	unitCode u1;
	unitCode u2;
	logic [5:0] x6;
	logic baseRange;
	logic pairRange;
	logic fpRange;

	// ==================================================
	// Slot extraction and latch
	// ==================================================
	always_comb begin
		case (slot)
			2'd0: slotBits = bundle[SYL_W-1:0];
			2'd1: slotBits = bundle[2*SYL_W-1:SYL_W];
			default: slotBits = bundle[3*SYL_W-1:2*SYL_W];
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			tmpl <= 5'h00;
			slotOut <= 2'd0;
		end else if (selSlot) begin
			tmpl <= bundle[BUNDLE_W-1 -: 5];
			slotOut <= slot;
		end
	end

	always_ff @(posedge clk) begin
		if (selSlot) begin
			syl <= slotBits;
			addrOut <= addrIn;
		end
	end

	// ==================================================
	// Template to unit table
	// ==================================================
	always_comb begin
		{u0, u1, u2} = {UNIT_NONE, UNIT_NONE, UNIT_NONE};
		case (tmpl)
			5'h0A, 5'h0B: {u0, u1, u2} = {UNIT_M, UNIT_M, UNIT_I};
			5'h0C, 5'h0D: {u0, u1, u2} = {UNIT_M, UNIT_F, UNIT_I};
			5'h0E, 5'h0F: {u0, u1, u2} = {UNIT_M, UNIT_M, UNIT_F};
			5'h10, 5'h11: {u0, u1, u2} = {UNIT_M, UNIT_I, UNIT_B};
			5'h12, 5'h13: {u0, u1, u2} = {UNIT_M, UNIT_B, UNIT_B};
			5'h16, 5'h17: {u0, u1, u2} = {UNIT_B, UNIT_B, UNIT_B};
			5'h18, 5'h19: {u0, u1, u2} = {UNIT_M, UNIT_M, UNIT_B};
			5'h1C, 5'h1D: {u0, u1, u2} = {UNIT_M, UNIT_F, UNIT_B};
			default: {u0, u1, u2} = {UNIT_NONE, UNIT_NONE, UNIT_NONE};
		endcase
		case (slotOut)
			2'd0: unit = u0;
			2'd1: unit = u1;
			2'd2: unit = u2;
			default: unit = UNIT_NONE;
		endcase
	end

	// ==================================================
	// Type from major opcode
	// ==================================================
	always_comb begin
		itype = IT_UNIMP;
		case (unit)
			UNIT_M: begin
				case (syl.regView.major)
					4'h0, 4'h1: itype = IT_MEMMGNT;
					4'h4: itype = IT_INTLDREG;
					4'h5: itype = IT_INTLDSTIMM;
					4'h6: itype = IT_FPLDSTREG;
					4'h7: itype = IT_FPLDSTIMM;
					4'h8: itype = IT_ALU;
					4'h9: itype = IT_ADD;
					4'hC, 4'hD, 4'hE: itype = IT_CMP;
					default: itype = IT_UNIMP;
				endcase
			end
			UNIT_I: begin
				case (syl.regView.major)
					4'h0: itype = IT_MISC;
					4'h4: itype = IT_DEPOSIT;
					4'h5: itype = IT_SHIFT;
					4'h6: itype = IT_MOVL;
					4'h7: itype = IT_MPY;
					4'h8: itype = IT_ALU;
					4'h9: itype = IT_ADD;
					4'hC, 4'hD, 4'hE: itype = IT_CMP;
					default: itype = IT_UNIMP;
				endcase
			end
			UNIT_F: begin
				case (syl.regView.major)
					4'h0, 4'h1: itype = IT_FPMISC;
					4'h4: itype = IT_FPCMP;
					4'h5: itype = IT_FPCLASS;
					4'h8, 4'h9: itype = IT_FPFMA;
					4'hA, 4'hB: itype = IT_FPFMS;
					4'hC, 4'hD: itype = IT_FPFNMA;
					4'hE: itype = IT_SELECT;
					default: itype = IT_UNIMP;
				endcase
			end
			UNIT_B: begin
				case (syl.regView.major)
					4'h0: itype = IT_INDBRANCH;
					4'h1: itype = IT_INDCALL;
					4'h2: itype = IT_NOP;
					4'h4: itype = IT_RELBRANCH;
					4'h5: itype = IT_RELCALL;
					default: itype = IT_UNIMP;
				endcase
			end
			default: itype = IT_UNIMP;
		endcase
	end

	// ==================================================
	// FP load detect, memory view
	// ==================================================
	assign x6 = syl.memView.x6;
	assign baseRange = (x6 <= 6'h0F) || (x6 == 6'h1B) || (x6 inside {[6'h20:6'h27]});
	// Paired forms skip every fourth x6 code
	assign pairRange = ((x6 <= 6'h0F) || (x6 inside {[6'h20:6'h27]})) && (x6[1:0] != 2'b00);

	always_comb begin
		case ({syl.memView.m, syl.memView.x})
			2'b00: fpRange = baseRange;
			2'b01: fpRange = pairRange || (x6 inside {[6'h1C:6'h1F]});
			2'b10: fpRange = baseRange || (x6 inside {[6'h2C:6'h2F]});
			default: fpRange = pairRange;
		endcase
	end

	assign fpLoad = (unit == UNIT_M) && (syl.memView.major == 4'h6) && fpRange;

	// Register fields pass straight through
	assign qp = syl.regView.qp;
	assign r1 = syl.regView.r1;
	assign r2 = syl.regView.r2;
	assign r3 = syl.regView.r3;

endmodule

// File: hw/bundleMem.sv
// Bundle memory
// Block storage of 128-bit bundles with one write port and a read
// address captured on each bundle load
`timescale 1ns/1ns

module bundleMem #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic clk,
	input  logic we,
	input  logic [$clog2(IMEM_DEPTH)-1:0] wrAddr,
	input  logic [bundlePkg::BUNDLE_W-1:0] wrData,
	input  logic loadBundle,
	input  logic [$clog2(IMEM_DEPTH)-1:0] rdAddr,
	output logic [bundlePkg::BUNDLE_W-1:0] bundle
);

	import bundlePkg::*;

	logic [BUNDLE_W-1:0] mem [IMEM_DEPTH];
	logic [$clog2(IMEM_DEPTH)-1:0] rdAddrQ;

	always_ff @(posedge clk) begin
		if (we)
			mem[wrAddr] <= wrData;
		// Held for all three slots of the bundle
		if (loadBundle)
			rdAddrQ <= rdAddr;
	end

	assign bundle = mem[rdAddrQ];

endmodule

// File: hw/fetchCounter.sv
// Fetch counter
// Warm-up timer, bundle pointer, slot index and remaining bundle count
`timescale 1ns/1ns

module fetchCounter #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic clk,
	input  logic rst_i,
	input  logic start,
	input  logic [$clog2(IMEM_DEPTH)-1:0] startAddr,
	input  logic [7:0] numBundles,
	input  logic warmStep,
	input  logic nextSlot,
	input  logic nextBundle,
	output logic [$clog2(IMEM_DEPTH)-1:0] bundleAddr,
	output logic [1:0] slot,
	output logic warmDone,
	output logic lastSlot,
	output logic lastBundle
);

	localparam int AW = $clog2(IMEM_DEPTH);

	logic [2:0] warmTimer;
	logic [7:0] remaining;
	logic active;
	logic ready;

	// Timer parks at 4 once warm-up is over, which marks the idle phase
	assign ready = warmTimer[2] && !active;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			warmTimer <= 3'd0;
			active <= 1'b0;
			slot <= 2'd0;
			remaining <= 8'd0;
			bundleAddr <= '0;
		end else begin
			if (warmStep)
				warmTimer <= warmTimer + 3'd1;
			if (start && ready) begin
				active <= 1'b1;
				bundleAddr <= startAddr;
				remaining <= numBundles;
				slot <= 2'd0;
			end else begin
				if (nextSlot)
					slot <= lastSlot ? 2'd0 : slot + 2'd1;
				if (nextBundle) begin
					// Wrap at the end of bundle memory
					bundleAddr <= (bundleAddr == AW'(IMEM_DEPTH - 1)) ? '0 : bundleAddr + 1'b1;
					remaining <= remaining - 8'd1;
					if (lastBundle)
						active <= 1'b0;
				end
			end
		end
	end

	assign warmDone = (warmTimer == 3'd3);
	assign lastSlot = (slot == 2'd2);
	assign lastBundle = (remaining == 8'd1);

endmodule

// File: hw/bundleSequencer.sv
// Bundle sequencer
// Steps warm-up, bundle load, slot select and emit for each bundle,
// and issues the step strobes to the counter, decoder and register file
`timescale 1ns/1ns

module bundleSequencer (
	input  logic clk,
	input  logic rst_i,
	input  logic start,
	input  logic warmDone,
	input  logic lastSlot,
	input  logic lastBundle,
	output logic warmStep,
	output logic loadBundle,
	output logic selSlot,
	output logic rdReg,
	output logic nextSlot,
	output logic nextBundle,
	output logic decValid,
	output logic busy,
	output logic done
);

	localparam logic [2:0] S_WARMUP = 3'd0;
	localparam logic [2:0] S_IDLE = 3'd1;
	localparam logic [2:0] S_LOAD = 3'd2;
	localparam logic [2:0] S_SLOT = 3'd3;
	localparam logic [2:0] S_EMIT = 3'd4;

	logic [2:0] state;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= S_WARMUP;
			decValid <= 1'b0;
			done <= 1'b0;
		end else begin
			// Outputs follow the emit state by one cycle
			decValid <= (state == S_EMIT);
			done <= nextBundle && lastBundle;
			case (state)
				S_WARMUP: if (warmDone) state <= S_IDLE;
				S_IDLE: if (start) state <= S_LOAD;
				S_LOAD: state <= S_SLOT;
				S_SLOT: state <= S_EMIT;
				S_EMIT: begin
					if (!lastSlot)
						state <= S_SLOT;
					else if (lastBundle)
						state <= S_IDLE;
					else
						state <= S_LOAD;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Step strobes, one state each
	assign warmStep = (state == S_WARMUP);
	assign loadBundle = (state == S_LOAD);
	assign selSlot = (state == S_SLOT);
	assign rdReg = (state == S_EMIT);
	assign nextSlot = (state == S_EMIT);
	assign nextBundle = (state == S_EMIT) && lastSlot;

	assign busy = loadBundle || selSlot || rdReg;

endmodule

// File: hw/bundlePkg.sv
// Bundle front end shared definitions
// Widths, execution unit codes, instruction type codes and the syllable layout
package bundlePkg;

	// ==================================================
	// Widths
	// ==================================================
	localparam int SYL_W = 41;
	localparam int BUNDLE_W = 128;
	localparam int REG_W = 80;
	localparam int RADDR_W = 7;
	localparam int QP_W = 6;

	// Bundle layout: template in the top 5 bits, slot 0 in the low syllable

	// ==================================================
	// Execution unit codes
	// ==================================================
	typedef logic [2:0] unitCode;
	localparam unitCode UNIT_M = 3'd0;
	localparam unitCode UNIT_I = 3'd1;
	localparam unitCode UNIT_F = 3'd2;
	localparam unitCode UNIT_B = 3'd3;
	localparam unitCode UNIT_NONE = 3'd7;

	// ==================================================
	// Coarse instruction types
	// ==================================================
	typedef logic [4:0] itype;
	localparam itype IT_MEMMGNT = 5'd0;
	localparam itype IT_INTLDREG = 5'd1;
	localparam itype IT_INTLDSTIMM = 5'd2;
	localparam itype IT_FPLDSTREG = 5'd3;
	localparam itype IT_FPLDSTIMM = 5'd4;
	localparam itype IT_ALU = 5'd5;
	localparam itype IT_ADD = 5'd6;
	localparam itype IT_CMP = 5'd7;
	localparam itype IT_MISC = 5'd8;
	localparam itype IT_DEPOSIT = 5'd9;
	localparam itype IT_SHIFT = 5'd10;
	localparam itype IT_MOVL = 5'd11;
	localparam itype IT_MPY = 5'd12;
	localparam itype IT_FPMISC = 5'd13;
	localparam itype IT_FPCMP = 5'd14;
	localparam itype IT_FPCLASS = 5'd15;
	localparam itype IT_FPFMA = 5'd16;
	localparam itype IT_FPFMS = 5'd17;
	localparam itype IT_FPFNMA = 5'd18;
	localparam itype IT_SELECT = 5'd19;
	localparam itype IT_INDBRANCH = 5'd20;
	localparam itype IT_INDCALL = 5'd21;
	localparam itype IT_NOP = 5'd22;
	localparam itype IT_RELBRANCH = 5'd23;
	localparam itype IT_RELCALL = 5'd24;
	localparam itype IT_UNIMP = 5'd31;

	// One syllable seen as a register op or as a memory op
	typedef union packed {
		struct packed {
			logic [3:0] major;
			logic [9:0] upper;
			logic [RADDR_W-1:0] r3;
			logic [RADDR_W-1:0] r2;
			logic [RADDR_W-1:0] r1;
			logic [QP_W-1:0] qp;
		} regView;
		struct packed {
			logic [3:0] major;
			logic m;
			logic [5:0] x6;
			logic [1:0] hint;
			logic x;
			logic [26:0] rest;
		} memView;
	} syllable_u;

endpackage
